/* filelist.f */
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_retire.sv
src/rv_core.sv
tests/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only --timing --timescale 1ns/1ps
TOP       := tb_rv_core
FILELIST  := filelist.f
OBJDIR    := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* tests/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;

  localparam logic [31:0] RESET_PC = 32'h0000_0100;
  localparam int PROG_LEN = 256;
  localparam int TIMEOUT_CYCLES = PROG_LEN + 4 + 10 + 20;

  logic          clk;
  logic          rst;
  insn_t         imem_data;
  xlen_t         imem_addr;
  xlen_t         trace_pc;
  insn_t         trace_insn;
  cycle_status_e trace_status;
  logic          trace_rd_we;
  reg_addr_t     trace_rd;
  xlen_t         trace_rd_data;

  integer      seed;
  int          cycles;
  int          errs [1:5];
  string       test_names [1:5];
  logic [31:0] prog [PROG_LEN];
  logic        exp_we [PROG_LEN];
  logic [4:0]  exp_rd [PROG_LEN];
  logic [31:0] exp_val [PROG_LEN];
  logic [31:0] prefix_exp [4];

  rv_core #(
    .RESET_PC(RESET_PC)
  ) u_dut (
    .clk          (clk),
    .rst          (rst),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .trace_rd_we  (trace_rd_we),
    .trace_rd     (trace_rd),
    .trace_rd_data(trace_rd_data)
  );

  always #4 clk = ~clk;

  // words past the program read as zero, an unknown opcode
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - RESET_PC) >> 2;
    if (addr >= RESET_PC && idx < PROG_LEN) begin
      return prog[idx[7:0]];
    end
    return 32'h0000_0000;
  endfunction

  // one-cycle read latency on the instruction port
  always @(posedge clk) begin
    imem_data <= fetch_word(imem_addr);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the trace never completed", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // rv32i integer result, alt picks sub and sra
  function automatic logic [31:0] alu_value(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    case (f3)
      3'b000: res = alt ? a - b : a + b;
      3'b001: res = a << b[4:0];
      3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: res = (a < b) ? 32'd1 : 32'd0;
      3'b100: res = a ^ b;
      3'b101: begin
        if (alt) begin
          res = $unsigned($signed(a) >>> b[4:0]);
        end else begin
          res = a >> b[4:0];
        end
      end
      3'b110: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  task automatic build_program();
    logic [31:0] r;
    logic [31:0] v;
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    // addi x5 = 0x123, then three readers of x5
    prog[0] = {12'h123, 5'd0, 3'b000, 5'd5, 7'h13};
    prog[1] = {12'h001, 5'd5, 3'b000, 5'd6, 7'h13};
    prog[2] = {12'h002, 5'd5, 3'b000, 5'd7, 7'h13};
    prog[3] = {12'h003, 5'd5, 3'b000, 5'd8, 7'h13};
    prefix_exp[0] = 32'h0000_0123;
    prefix_exp[1] = 32'h0000_0001;
    prefix_exp[2] = 32'h0000_0002;
    prefix_exp[3] = 32'h0000_0126;
    for (int i = 4; i < PROG_LEN; i++) begin
      r = $random(seed);
      v = $random(seed);
      // x0 to x15 only, so dependencies are frequent
      rd = {1'b0, r[7:4]};
      rs1 = {1'b0, r[11:8]};
      rs2 = {1'b0, r[15:12]};
      f3 = r[18:16];
      case (r[3:0])
        4'd0: begin
          opc = v[6:0];
          if (opc == 7'h13 || opc == 7'h33 || opc == 7'h37 || opc == 7'h17) begin
            opc = 7'h7f;
          end
          prog[i] = {v[31:7], opc};
        end
        4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6: begin
          if (f3 == 3'b001 || f3 == 3'b101) begin
            f7 = (f3 == 3'b101 && v[25]) ? 7'h20 : 7'h00;
            prog[i] = {f7, v[24:20], rs1, f3, rd, 7'h13};
          end else begin
            prog[i] = {v[31:20], rs1, f3, rd, 7'h13};
          end
        end
        4'd7, 4'd8, 4'd9, 4'd10, 4'd11, 4'd12: begin
          f7 = ((f3 == 3'b000 || f3 == 3'b101) && v[25]) ? 7'h20 : 7'h00;
          prog[i] = {f7, rs2, rs1, f3, rd, 7'h33};
        end
        4'd13: prog[i] = {v[31:12], rd, 7'h37};
        4'd14: prog[i] = {v[31:12], rd, 7'h17};
        // random funct7, mostly illegal
        default: prog[i] = {v[31:25], rs2, rs1, f3, rd, 7'h33};
      endcase
    end
  endtask

  task automatic compute_expected();
    logic [31:0] regs [32];
    logic [31:0] insn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] val;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic        legal;
    logic        alt;
    for (int j = 0; j < 32; j++) begin
      regs[j] = 32'h0000_0000;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      // no forwarding, so only writes from three or more slots back are seen
      if (i >= 3 && exp_we[i-3]) begin
        regs[exp_rd[i-3]] = exp_val[i-3];
      end
      insn = prog[i];
      f3 = insn[14:12];
      f7 = insn[31:25];
      a = regs[insn[19:15]];
      b = regs[insn[24:20]];
      imm_i = {{20{insn[31]}}, insn[31:20]};
      imm_u = {insn[31:12], 12'h000};
      legal = 1'b0;
      val = 32'h0000_0000;
      case (insn[6:0])
        7'h13: begin
          alt = (f3 == 3'b101) && (f7 == 7'h20);
          legal = (f3 != 3'b001 && f3 != 3'b101) || f7 == 7'h00 || alt;
          val = alu_value(f3, alt, a, imm_i);
        end
        7'h33: begin
          alt = (f7 == 7'h20);
          legal = (f7 == 7'h00) || (alt && (f3 == 3'b000 || f3 == 3'b101));
          val = alu_value(f3, alt, a, b);
        end
        7'h37: begin
          legal = 1'b1;
          val = imm_u;
        end
        7'h17: begin
          legal = 1'b1;
          val = RESET_PC + 4 * i + imm_u;
        end
        default: legal = 1'b0;
      endcase
      exp_we[i] = legal && (insn[11:7] != 5'd0);
      exp_rd[i] = insn[11:7];
      exp_val[i] = val;
    end
  endtask

  task automatic report_mismatch(input int id, input string name,
                                 input logic [31:0] got, input logic [31:0] exp);
    $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    errs[id]++;
  endtask

  task automatic report_test(input int id);
    $display("test %0d %s: %s with %0d errors", id, test_names[id],
             (errs[id] == 0) ? "passed" : "failed", errs[id]);
  endtask

  initial begin
    int k;
    int total;
    int passed;
    clk = 1'b0;
    rst = 1'b1;
    imem_data = 32'h0000_0000;
    cycles = 0;
    seed = 32'h1b97_6bd7;
    for (int t = 1; t <= 5; t++) begin
      errs[t] = 0;
    end
    test_names[1] = "reset status window";
    test_names[2] = "pc and instruction sequence";
    test_names[3] = "register writes";
    test_names[4] = "no-op retirement";
    test_names[5] = "three-slot visibility";
    build_program();
    compute_expected();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // sample the trace mid-cycle, away from the clock edge
    for (int n = 0; n < 4 + PROG_LEN; n++) begin
      @(negedge clk);
      // fetch address runs four slots ahead of the trace
      if (imem_addr !== RESET_PC + 4 * n) begin
        report_mismatch(2, "imem_addr", imem_addr, RESET_PC + 4 * n);
      end
      if (n < 4) begin
        if (trace_status !== CYCLE_RESET) begin
          report_mismatch(1, "trace_status", {29'd0, trace_status}, {29'd0, CYCLE_RESET});
        end
        if (trace_rd_we !== 1'b0) begin
          report_mismatch(1, "trace_rd_we", {31'd0, trace_rd_we}, 32'd0);
        end
      end else begin
        k = n - 4;
        if (trace_status !== CYCLE_NO_STALL) begin
          report_mismatch((k == 0) ? 1 : 2, "trace_status", {29'd0, trace_status},
                          {29'd0, CYCLE_NO_STALL});
        end
        if (trace_pc !== RESET_PC + 4 * k) begin
          report_mismatch(2, "trace_pc", trace_pc, RESET_PC + 4 * k);
        end
        if (trace_insn !== prog[k]) begin
          report_mismatch(2, "trace_insn", trace_insn, prog[k]);
        end
        if (exp_we[k]) begin
          if (trace_rd_we !== 1'b1) begin
            report_mismatch(3, "trace_rd_we", {31'd0, trace_rd_we}, 32'd1);
          end
          if (trace_rd !== exp_rd[k]) begin
            report_mismatch(3, "trace_rd", {27'd0, trace_rd}, {27'd0, exp_rd[k]});
          end
          if (trace_rd_data !== exp_val[k]) begin
            report_mismatch(3, "trace_rd_data", trace_rd_data, exp_val[k]);
          end
        end else if (trace_rd_we !== 1'b0) begin
          report_mismatch(4, "trace_rd_we", {31'd0, trace_rd_we}, 32'd0);
        end
        if (k < 4 && trace_rd_data !== prefix_exp[k]) begin
          report_mismatch(5, "trace_rd_data", trace_rd_data, prefix_exp[k]);
        end
        if (k == 0) begin
          report_test(1);
        end
        if (k == 3) begin
          report_test(5);
        end
      end
    end
    report_test(2);
    report_test(3);
    report_test(4);
    total = 0;
    passed = 0;
    for (int t = 1; t <= 5; t++) begin
      total += errs[t];
      if (errs[t] == 0) begin
        passed++;
      end
    end
    $display("tests passed %0d of 5, total errors %0d", passed, total);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter rv_pkg::xlen_t RESET_PC = '0
) (
  input  wire                   clk,
  input  wire                   rst,
  output rv_pkg::xlen_t         imem_addr,
  input  wire rv_pkg::insn_t    imem_data,
  output rv_pkg::xlen_t         trace_pc,
  output rv_pkg::insn_t         trace_insn,
  output rv_pkg::cycle_status_e trace_status,
  output logic                  trace_rd_we,
  output rv_pkg::reg_addr_t     trace_rd,
  output rv_pkg::xlen_t         trace_rd_data
);
  import rv_pkg::*;

  // fetch to decode
  xlen_t         d_pc;
  cycle_status_e d_status;

  // register file read ports
  reg_addr_t rs1;
  reg_addr_t rs2;
  xlen_t     rs1_data;
  xlen_t     rs2_data;

  // decode to execute
  xlen_t         x_pc;
  insn_t         x_insn;
  cycle_status_e x_status;
  alu_op_t       x_op;
  xlen_t         x_a;
  xlen_t         x_b;
  reg_addr_t     x_rd;
  logic          x_rd_we;

  // execute to retire
  xlen_t         m_pc;
  insn_t         m_insn;
  cycle_status_e m_status;
  xlen_t         m_result;
  reg_addr_t     m_rd;
  logic          m_rd_we;

  // retire to register file
  logic      wb_we;
  reg_addr_t wb_rd;
  xlen_t     wb_data;

  rv_fetch #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .clk      (clk),
    .rst      (rst),
    .imem_addr(imem_addr),
    .d_pc     (d_pc),
    .d_status (d_status)
  );

  rv_decode u_decode (
    .clk      (clk),
    .rst      (rst),
    .d_pc     (d_pc),
    .d_status (d_status),
    .imem_data(imem_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .x_pc     (x_pc),
    .x_insn   (x_insn),
    .x_status (x_status),
    .x_op     (x_op),
    .x_a      (x_a),
    .x_b      (x_b),
    .x_rd     (x_rd),
    .x_rd_we  (x_rd_we)
  );

  rv_regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .rs1     (rs1),
    .rs2     (rs2),
    .wb_we   (wb_we),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  rv_execute u_execute (
    .clk     (clk),
    .rst     (rst),
    .x_pc    (x_pc),
    .x_insn  (x_insn),
    .x_status(x_status),
    .x_op    (x_op),
    .x_a     (x_a),
    .x_b     (x_b),
    .x_rd    (x_rd),
    .x_rd_we (x_rd_we),
    .m_pc    (m_pc),
    .m_insn  (m_insn),
    .m_status(m_status),
    .m_result(m_result),
    .m_rd    (m_rd),
    .m_rd_we (m_rd_we)
  );

  rv_retire u_retire (
    .clk          (clk),
    .rst          (rst),
    .m_pc         (m_pc),
    .m_insn       (m_insn),
    .m_status     (m_status),
    .m_result     (m_result),
    .m_rd         (m_rd),
    .m_rd_we      (m_rd_we),
    .wb_we        (wb_we),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .trace_rd_we  (trace_rd_we),
    .trace_rd     (trace_rd),
    .trace_rd_data(trace_rd_data)
  );

endmodule

`default_nettype wire

/* src/rv_retire.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_retire (
  input  wire                        clk,
  input  wire                        rst,
  input  wire rv_pkg::xlen_t         m_pc,
  input  wire rv_pkg::insn_t         m_insn,
  input  wire rv_pkg::cycle_status_e m_status,
  input  wire rv_pkg::xlen_t         m_result,
  input  wire rv_pkg::reg_addr_t     m_rd,
  input  wire                        m_rd_we,
  output logic                       wb_we,
  output rv_pkg::reg_addr_t          wb_rd,
  output rv_pkg::xlen_t              wb_data,
  output rv_pkg::xlen_t              trace_pc,
  output rv_pkg::insn_t              trace_insn,
  output rv_pkg::cycle_status_e      trace_status,
  output logic                       trace_rd_we,
  output rv_pkg::reg_addr_t          trace_rd,
  output rv_pkg::xlen_t              trace_rd_data
);
  import rv_pkg::*;

  xlen_t         w_pc;
  insn_t         w_insn;
  cycle_status_e w_status;
  logic          w_rd_we;
  reg_addr_t     w_rd;
  xlen_t         w_data;

  // writeback stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      w_pc <= '0;
      w_insn <= '0;
      w_status <= CYCLE_RESET;
      w_rd_we <= 1'b0;
    end else begin
      w_pc <= m_pc;
      w_insn <= m_insn;
      w_status <= m_status;
      w_rd_we <= m_rd_we;
    end
  end

  always_ff @(posedge clk) begin
    w_rd <= m_rd;
    w_data <= m_result;
  end

  // register file write lands at the end of this cycle
  assign wb_we = w_rd_we;
  assign wb_rd = w_rd;
  assign wb_data = w_data;

  assign trace_pc = w_pc;
  assign trace_insn = w_insn;
  assign trace_status = w_status;
  assign trace_rd_we = w_rd_we;
  assign trace_rd = w_rd;
  assign trace_rd_data = w_data;

endmodule

`default_nettype wire

/* src/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire                        clk,
  input  wire                        rst,
  input  wire rv_pkg::xlen_t         x_pc,
  input  wire rv_pkg::insn_t         x_insn,
  input  wire rv_pkg::cycle_status_e x_status,
  input  wire rv_pkg::alu_op_t       x_op,
  input  wire rv_pkg::xlen_t         x_a,
  input  wire rv_pkg::xlen_t         x_b,
  input  wire rv_pkg::reg_addr_t     x_rd,
  input  wire                        x_rd_we,
  output rv_pkg::xlen_t              m_pc,
  output rv_pkg::insn_t              m_insn,
  output rv_pkg::cycle_status_e      m_status,
  output rv_pkg::xlen_t              m_result,
  output rv_pkg::reg_addr_t          m_rd,
  output logic                       m_rd_we
);
  import rv_pkg::*;

  xlen_t      result;
  logic [4:0] shamt;

  // shifts use only the low five bits of operand b
  assign shamt = x_b[4:0];

  always_comb begin
    case (x_op)
      ALU_ADD, ALU_ADD_PC: begin
        result = x_a + x_b;
      end
      ALU_SUB: begin
        result = x_a - x_b;
      end
      ALU_SLL: begin
        result = x_a << shamt;
      end
      ALU_SLT: begin
        result = {31'b0, $signed(x_a) < $signed(x_b)};
      end
      ALU_SLTU: begin
        result = {31'b0, x_a < x_b};
      end
      ALU_XOR: begin
        result = x_a ^ x_b;
      end
      ALU_SRL: begin
        result = x_a >> shamt;
      end
      ALU_SRA: begin
        result = $unsigned($signed(x_a) >>> shamt);
      end
      ALU_OR: begin
        result = x_a | x_b;
      end
      ALU_AND: begin
        result = x_a & x_b;
      end
      ALU_PASS_B: begin
        result = x_b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // memory stage register, nothing else happens in that stage
  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc <= '0;
      m_insn <= '0;
      m_status <= CYCLE_RESET;
      m_rd_we <= 1'b0;
    end else begin
      m_pc <= x_pc;
      m_insn <= x_insn;
      m_status <= x_status;
      m_rd_we <= x_rd_we;
    end
  end

  always_ff @(posedge clk) begin
    m_result <= result;
    m_rd <= x_rd;
  end

endmodule

`default_nettype wire

/* src/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire                    clk,
  input  wire                    rst,
  input  wire rv_pkg::reg_addr_t rs1,
  input  wire rv_pkg::reg_addr_t rs2,
  input  wire                    wb_we,
  input  wire rv_pkg::reg_addr_t wb_rd,
  input  wire rv_pkg::xlen_t     wb_data,
  output rv_pkg::xlen_t          rs1_data,
  output rv_pkg::xlen_t          rs2_data
);
  import rv_pkg::*;

  localparam int NUM_REGS = 32;

  xlen_t regs [NUM_REGS];

  // x0 is never written, decode already dropped those writes
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign rs1_data = (wb_we && (wb_rd == rs1)) ? wb_data : regs[rs1];
  assign rs2_data = (wb_we && (wb_rd == rs2)) ? wb_data : regs[rs2];

endmodule

`default_nettype wire

/* src/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  wire                        clk,
  input  wire                        rst,
  input  wire rv_pkg::xlen_t         d_pc,
  input  wire rv_pkg::cycle_status_e d_status,
  input  wire rv_pkg::insn_t         imem_data,
  input  wire rv_pkg::xlen_t         rs1_data,
  input  wire rv_pkg::xlen_t         rs2_data,
  output rv_pkg::reg_addr_t          rs1,
  output rv_pkg::reg_addr_t          rs2,
  output rv_pkg::xlen_t              x_pc,
  output rv_pkg::insn_t              x_insn,
  output rv_pkg::cycle_status_e      x_status,
  output rv_pkg::alu_op_t            x_op,
  output rv_pkg::xlen_t              x_a,
  output rv_pkg::xlen_t              x_b,
  output rv_pkg::reg_addr_t          x_rd,
  output logic                       x_rd_we
);
  import rv_pkg::*;

  localparam logic [6:0] FUNCT7_BASE = 7'b000_0000;
  localparam logic [6:0] FUNCT7_ALT = 7'b010_0000;

  insn_t      insn;
  opcode_t    opcode;
  reg_addr_t  rd;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_u;
  alu_op_t    op;
  xlen_t      a;
  xlen_t      b;
  logic       legal;

  // funct3 to operation, shared by reg-imm and reg-reg
  function automatic alu_op_t base_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // reset bubbles decode as an all-zero word, which writes nothing
  assign insn = (d_status == CYCLE_NO_STALL) ? imem_data : '0;

  assign opcode = insn[6:0];
  assign rd = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1 = insn[19:15];
  assign rs2 = insn[24:20];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    op = ALU_ADD;
    a = rs1_data;
    b = rs2_data;
    legal = 1'b0;
    case (opcode)
      OPCODE_REG_IMM: begin
        b = imm_i;
        op = base_op(funct3);
        legal = 1'b1;
        // shift immediates carry funct7 in the upper bits
        if (funct3 == 3'b001) begin
          legal = (funct7 == FUNCT7_BASE);
        end else if (funct3 == 3'b101) begin
          if (funct7 == FUNCT7_ALT) begin
            op = ALU_SRA;
          end else begin
            legal = (funct7 == FUNCT7_BASE);
          end
        end
      end
      OPCODE_REG_REG: begin
        if (funct7 == FUNCT7_BASE) begin
          op = base_op(funct3);
          legal = 1'b1;
        end else if (funct7 == FUNCT7_ALT && funct3 == 3'b000) begin
          op = ALU_SUB;
          legal = 1'b1;
        end else if (funct7 == FUNCT7_ALT && funct3 == 3'b101) begin
          op = ALU_SRA;
          legal = 1'b1;
        end
      end
      OPCODE_LUI: begin
        op = ALU_PASS_B;
        b = imm_u;
        legal = 1'b1;
      end
      OPCODE_AUIPC: begin
        op = ALU_ADD_PC;
        a = d_pc;
        b = imm_u;
        legal = 1'b1;
      end
      default: begin
        // anything else retires as a no-op
        legal = 1'b0;
      end
    endcase
  end

  // execute stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc <= '0;
      x_insn <= '0;
      x_status <= CYCLE_RESET;
      x_rd_we <= 1'b0;
    end else begin
      x_pc <= d_pc;
      x_insn <= insn;
      x_status <= d_status;
      x_rd_we <= legal && (rd != 5'd0);
    end
  end

  always_ff @(posedge clk) begin
    x_op <= op;
    x_a <= a;
    x_b <= b;
    x_rd <= rd;
  end

endmodule

`default_nettype wire

/* src/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
  parameter rv_pkg::xlen_t RESET_PC = '0
) (
  input  wire                   clk,
  input  wire                   rst,
  output rv_pkg::xlen_t         imem_addr,
  output rv_pkg::xlen_t         d_pc,
  output rv_pkg::cycle_status_e d_status
);
  import rv_pkg::*;

  xlen_t pc;

  // sequential fetch, no redirects
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  assign imem_addr = pc;

  // the word for pc shows up one cycle later, so delay pc to match
  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc <= '0;
      d_status <= CYCLE_RESET;
    end else begin
      d_pc <= pc;
      d_status <= CYCLE_NO_STALL;
    end
  end

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // word widths
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [6:0] opcode_t;

  // operation code handed from decode to execute
  typedef logic [4:0] alu_op_t;

  // major opcodes that the pipeline executes
  localparam opcode_t OPCODE_REG_IMM = 7'b00_100_11;
  localparam opcode_t OPCODE_REG_REG = 7'b01_100_11;
  localparam opcode_t OPCODE_LUI = 7'b01_101_11;
  localparam opcode_t OPCODE_AUIPC = 7'b00_101_11;

  // alu operations
  localparam alu_op_t ALU_ADD = 5'd0;
  localparam alu_op_t ALU_SUB = 5'd1;
  localparam alu_op_t ALU_SLL = 5'd2;
  localparam alu_op_t ALU_SLT = 5'd3;
  localparam alu_op_t ALU_SLTU = 5'd4;
  localparam alu_op_t ALU_XOR = 5'd5;
  localparam alu_op_t ALU_SRL = 5'd6;
  localparam alu_op_t ALU_SRA = 5'd7;
  localparam alu_op_t ALU_OR = 5'd8;
  localparam alu_op_t ALU_AND = 5'd9;
  // lui: operand b straight through
  localparam alu_op_t ALU_PASS_B = 5'd10;
  // auipc: pc arrives on operand a
  localparam alu_op_t ALU_ADD_PC = 5'd11;

  // what occupies writeback in a given cycle
  typedef enum logic [2:0] {
    CYCLE_INVALID = 3'd0,
    CYCLE_RESET = 3'd1,
    CYCLE_NO_STALL = 3'd2
  } cycle_status_e;

endpackage

`default_nettype wire
